// ==== source/isa_pkg.sv ====
// ARM-state branch encoding only; Thumb and link-register writes are not modelled.
`default_nettype none

package isa_pkg;

        // ARM condition field, bits 31 to 28.
        typedef enum logic [3:0] {
                COND_EQ, COND_NE, COND_CS, COND_CC,
                COND_MI, COND_PL, COND_VS, COND_VC,
                COND_HI, COND_LS, COND_GE, COND_LT,
                COND_GT, COND_LE, COND_AL, COND_NV
        } cond_t;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
                logic v;
        } flags_t;

        // B and BL share op class 101; bit 24 is the link bit.
        typedef struct packed {
                cond_t       cond;
                logic [2:0]  op_class;
                logic        link;
                logic [23:0] offset;
        } inst_t;

        localparam logic [2:0] OP_BRANCH = 3'b101;

        function automatic logic cond_pass(cond_t cond, flags_t flags);
                unique case (cond)
                COND_EQ: return flags.z;
                COND_NE: return !flags.z;
                COND_CS: return flags.c;
                COND_CC: return !flags.c;
                COND_MI: return flags.n;
                COND_PL: return !flags.n;
                COND_VS: return flags.v;
                COND_VC: return !flags.v;
                COND_HI: return flags.c && !flags.z;
                COND_LS: return !flags.c || flags.z;
                COND_GE: return flags.n == flags.v;
                COND_LT: return flags.n != flags.v;
                COND_GT: return !flags.z && (flags.n == flags.v);
                COND_LE: return flags.z || (flags.n != flags.v);
                COND_AL: return 1'b1;
                default: return 1'b0;
                endcase
        endfunction

endpackage

`default_nettype wire

// ==== source/predict_pkg.sv ====
// Two-bit saturating counters; a counter predicts taken when its upper bit is set.
`default_nettype none

package predict_pkg;

        typedef enum logic [1:0] {
                SNT = 2'd0,
                WNT = 2'd1,
                WT  = 2'd2,
                ST  = 2'd3
        } ctr_t;

        localparam int DEFAULT_DEPTH = 512;

        // Wrong guess moves one step toward the other side.
        function automatic ctr_t ctr_on_miss(ctr_t ctr);
                unique case (ctr)
                SNT:     return WNT;
                WNT:     return WT;
                WT:      return WNT;
                default: return WT;
                endcase
        endfunction

        // Right guess strengthens, except a weak not-taken falls back to SNT.
        function automatic ctr_t ctr_on_hit(ctr_t ctr);
                unique case (ctr)
                SNT:     return SNT;
                WNT:     return SNT;
                WT:      return ST;
                default: return ST;
                endcase
        endfunction

endpackage

`default_nettype wire

// ==== source/branch_predict.sv ====
// TABLE_DEPTH must be a power of two of at least 2; index is PC bits from bit 2 up.
`default_nettype none

module branch_predict
        import isa_pkg::*;
        import predict_pkg::*;
#(
        parameter int TABLE_DEPTH = DEFAULT_DEPTH
)
(
        input  logic                           i_clk,
        input  logic                           i_reset,
        input  logic                           i_flush,
        input  logic                           i_stall,
        input  logic                           i_redirect,
        input  logic                           i_val,
        input  inst_t                          i_inst,
        input  logic [31:0]                    i_pc,
        input  logic                           i_upd_val,
        input  logic [$clog2(TABLE_DEPTH)-1:0] i_upd_idx,
        input  logic                           i_upd_hit,
        output logic                           o_val,
        output inst_t                          o_inst,
        output logic [31:0]                    o_pc,
        output logic                           o_taken
);

        localparam int IDX_W = $clog2(TABLE_DEPTH);

        ctr_t ctr_q [TABLE_DEPTH];
        logic rd_taken;

        // Read sees the old value when an update hits the same entry.
        assign rd_taken = ctr_q[i_pc[IDX_W+1:2]][1];

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < TABLE_DEPTH; i++)
                        begin
                                ctr_q[i] <= SNT;
                        end
                end
                else if (i_upd_val && !i_stall)
                begin
                        if (i_upd_hit)
                                ctr_q[i_upd_idx] <= ctr_on_hit(ctr_q[i_upd_idx]);
                        else
                                ctr_q[i_upd_idx] <= ctr_on_miss(ctr_q[i_upd_idx]);
                end
        end

        // Control state of the stage.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_val   <= 1'b0;
                        o_taken <= 1'b0;
                end
                else if (i_stall)
                begin
                        o_val   <= o_val;
                        o_taken <= o_taken;
                end
                else if (i_redirect)
                begin
                        o_val   <= 1'b0;
                        o_taken <= 1'b0;
                end
                else
                begin
                        o_val   <= i_val;
                        o_taken <= rd_taken;
                end
        end

        // Payload just follows the pipe.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_inst <= i_inst;
                        o_pc   <= i_pc;
                end
        end

        a_upd_idx_known: assert property (@(posedge i_clk) disable iff (i_reset)
                i_upd_val |-> !$isunknown(i_upd_idx));

endmodule

`default_nettype wire

// ==== source/branch_decode.sv ====
// Only op class 101 counts as a branch; fetch gets the predicted target one stage early.
`default_nettype none

module branch_decode
        import isa_pkg::*;
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_flush,
        input  logic        i_stall,
        input  logic        i_redirect,
        input  logic        i_val,
        input  inst_t       i_inst,
        input  logic [31:0] i_pc,
        input  logic        i_taken,
        output logic        o_val,
        output inst_t       o_inst,
        output logic [31:0] o_pc,
        output logic        o_is_branch,
        output logic        o_pred_taken,
        output logic signed [31:0] o_offset,
        output logic        o_pred_val,
        output logic [31:0] o_pred_target
);

        logic               is_branch;
        logic signed [31:0] offset_ext;

        assign is_branch  = i_val && (i_inst.op_class == OP_BRANCH);
        assign offset_ext = {{8{i_inst.offset[23]}}, i_inst.offset};

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_val        <= 1'b0;
                        o_is_branch  <= 1'b0;
                        o_pred_taken <= 1'b0;
                        o_pred_val   <= 1'b0;
                end
                else if (i_stall)
                begin
                        o_val        <= o_val;
                        o_is_branch  <= o_is_branch;
                        o_pred_taken <= o_pred_taken;
                        o_pred_val   <= o_pred_val;
                end
                else if (i_redirect)
                begin
                        o_val        <= 1'b0;
                        o_is_branch  <= 1'b0;
                        o_pred_taken <= 1'b0;
                        o_pred_val   <= 1'b0;
                end
                else
                begin
                        o_val        <= i_val;
                        o_is_branch  <= is_branch;
                        // Counter bit is meaningless for non-branches.
                        o_pred_taken <= is_branch && i_taken;
                        o_pred_val   <= is_branch;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_inst        <= i_inst;
                        o_pc          <= i_pc;
                        o_offset      <= offset_ext;
                        o_pred_target <= i_pc + 32'd8 + {offset_ext[29:0], 2'b00};
                end
        end

        a_taken_is_branch: assert property (@(posedge i_clk) disable iff (i_reset)
                o_pred_taken |-> o_is_branch);

endmodule

`default_nettype wire

// ==== source/branch_execute.sv ====
// i_flags must stay constant while a branch sits in this stage.
`default_nettype none

module branch_execute
        import isa_pkg::*;
(
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_flush,
        input  logic               i_stall,
        input  logic               i_redirect,
        input  logic               i_val,
        input  inst_t              i_inst,
        input  logic [31:0]        i_pc,
        input  logic               i_is_branch,
        input  logic               i_pred_taken,
        input  logic signed [31:0] i_offset,
        input  flags_t             i_flags,
        output logic               o_val,
        output logic [31:0]        o_pc,
        output logic               o_is_branch,
        output logic               o_pred_taken,
        output logic               o_actual_taken,
        output logic [31:0]        o_actual_target
);

        logic actual_taken;

        assign actual_taken = i_val && i_is_branch && cond_pass(i_inst.cond, i_flags);

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_val          <= 1'b0;
                        o_is_branch    <= 1'b0;
                        o_pred_taken   <= 1'b0;
                        o_actual_taken <= 1'b0;
                end
                else if (i_stall)
                begin
                        o_val          <= o_val;
                        o_is_branch    <= o_is_branch;
                        o_pred_taken   <= o_pred_taken;
                        o_actual_taken <= o_actual_taken;
                end
                else if (i_redirect)
                begin
                        o_val          <= 1'b0;
                        o_is_branch    <= 1'b0;
                        o_pred_taken   <= 1'b0;
                        o_actual_taken <= 1'b0;
                end
                else
                begin
                        o_val          <= i_val;
                        o_is_branch    <= i_is_branch;
                        o_pred_taken   <= i_pred_taken;
                        o_actual_taken <= actual_taken;
                end
        end

        // Fall-through is the next word.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_pc            <= i_pc;
                        o_actual_target <= actual_taken ?
                                           i_pc + 32'd8 + {i_offset[29:0], 2'b00} :
                                           i_pc + 32'd4;
                end
        end

endmodule

`default_nettype wire

// ==== source/branch_result.sv ====
// Redirect and retire appear together; the counter write lands one edge after retire.
`default_nettype none

module branch_result #(
        parameter int TABLE_DEPTH = 512
)
(
        input  logic                           i_clk,
        input  logic                           i_reset,
        input  logic                           i_flush,
        input  logic                           i_stall,
        input  logic                           i_val,
        input  logic [31:0]                    i_pc,
        input  logic                           i_is_branch,
        input  logic                           i_pred_taken,
        input  logic                           i_actual_taken,
        input  logic [31:0]                    i_actual_target,
        output logic                           o_redirect_now,
        output logic                           o_retire_val,
        output logic [31:0]                    o_retire_pc,
        output logic                           o_mispredict,
        output logic                           o_redirect,
        output logic [31:0]                    o_redirect_pc,
        output logic                           o_upd_val,
        output logic [$clog2(TABLE_DEPTH)-1:0] o_upd_idx,
        output logic                           o_upd_hit
);

        localparam int IDX_W = $clog2(TABLE_DEPTH);

        logic mispredict;

        assign mispredict     = i_val && i_is_branch && (i_pred_taken != i_actual_taken);
        // Squashes the three younger stages at this same edge.
        assign o_redirect_now = mispredict;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        o_retire_val <= 1'b0;
                        o_mispredict <= 1'b0;
                        o_redirect   <= 1'b0;
                        o_upd_val    <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_retire_val <= i_val;
                        o_mispredict <= mispredict;
                        o_redirect   <= mispredict;
                        o_upd_val    <= i_val && i_is_branch;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                begin
                        o_retire_pc   <= i_pc;
                        o_redirect_pc <= i_actual_target;
                        o_upd_idx     <= i_pc[IDX_W+1:2];
                        o_upd_hit     <= !mispredict;
                end
        end

        a_redirect_retires: assert property (@(posedge i_clk) disable iff (i_reset)
                o_redirect |-> o_retire_val);

endmodule

`default_nettype wire

// ==== source/branch_unit_top.sv ====
// Upstream must hold its inputs while i_stall is high; TABLE_DEPTH is a power of two.
`default_nettype none

module branch_unit_top
        import isa_pkg::*;
        import predict_pkg::*;
#(
        parameter int TABLE_DEPTH = DEFAULT_DEPTH
)
(
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_flush,
        input  logic        i_stall,
        input  logic        i_val,
        input  inst_t       i_inst,
        input  logic [31:0] i_pc,
        input  flags_t      i_flags,
        output logic        o_pred_val,
        output logic        o_pred_taken,
        output logic [31:0] o_pred_target,
        output logic        o_retire_val,
        output logic [31:0] o_retire_pc,
        output logic        o_mispredict,
        output logic        o_redirect,
        output logic [31:0] o_redirect_pc
);

        logic                           p_val;
        inst_t                          p_inst;
        logic [31:0]                    p_pc;
        logic                           p_taken;
        logic                           d_val;
        inst_t                          d_inst;
        logic [31:0]                    d_pc;
        logic                           d_is_branch;
        logic signed [31:0]             d_offset;
        logic                           e_val;
        logic [31:0]                    e_pc;
        logic                           e_is_branch;
        logic                           e_pred_taken;
        logic                           e_actual_taken;
        logic [31:0]                    e_actual_target;
        logic                           redirect_now;
        logic                           upd_val;
        logic [$clog2(TABLE_DEPTH)-1:0] upd_idx;
        logic                           upd_hit;

        branch_predict #(.TABLE_DEPTH(TABLE_DEPTH)) u_predict (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_flush    (i_flush),
                .i_stall    (i_stall),
                .i_redirect (redirect_now),
                .i_val      (i_val),
                .i_inst     (i_inst),
                .i_pc       (i_pc),
                .i_upd_val  (upd_val),
                .i_upd_idx  (upd_idx),
                .i_upd_hit  (upd_hit),
                .o_val      (p_val),
                .o_inst     (p_inst),
                .o_pc       (p_pc),
                .o_taken    (p_taken)
        );

        branch_decode u_decode (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_flush       (i_flush),
                .i_stall       (i_stall),
                .i_redirect    (redirect_now),
                .i_val         (p_val),
                .i_inst        (p_inst),
                .i_pc          (p_pc),
                .i_taken       (p_taken),
                .o_val         (d_val),
                .o_inst        (d_inst),
                .o_pc          (d_pc),
                .o_is_branch   (d_is_branch),
                .o_pred_taken  (o_pred_taken),
                .o_offset      (d_offset),
                .o_pred_val    (o_pred_val),
                .o_pred_target (o_pred_target)
        );

        // Execute reads the same prediction that fetch sees.
        branch_execute u_execute (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_flush         (i_flush),
                .i_stall         (i_stall),
                .i_redirect      (redirect_now),
                .i_val           (d_val),
                .i_inst          (d_inst),
                .i_pc            (d_pc),
                .i_is_branch     (d_is_branch),
                .i_pred_taken    (o_pred_taken),
                .i_offset        (d_offset),
                .i_flags         (i_flags),
                .o_val           (e_val),
                .o_pc            (e_pc),
                .o_is_branch     (e_is_branch),
                .o_pred_taken    (e_pred_taken),
                .o_actual_taken  (e_actual_taken),
                .o_actual_target (e_actual_target)
        );

        branch_result #(.TABLE_DEPTH(TABLE_DEPTH)) u_result (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_flush         (i_flush),
                .i_stall         (i_stall),
                .i_val           (e_val),
                .i_pc            (e_pc),
                .i_is_branch     (e_is_branch),
                .i_pred_taken    (e_pred_taken),
                .i_actual_taken  (e_actual_taken),
                .i_actual_target (e_actual_target),
                .o_redirect_now  (redirect_now),
                .o_retire_val    (o_retire_val),
                .o_retire_pc     (o_retire_pc),
                .o_mispredict    (o_mispredict),
                .o_redirect      (o_redirect),
                .o_redirect_pc   (o_redirect_pc),
                .o_upd_val       (upd_val),
                .o_upd_idx       (upd_idx),
                .o_upd_hit       (upd_hit)
        );

endmodule

`default_nettype wire

// ==== verification/tb_branch_unit.sv ====
// Uses a 64-entry table so aliasing PCs are 256 bytes apart; needs concurrent assertion support.
`default_nettype none

module tb_branch_unit
        import isa_pkg::*;
        import predict_pkg::*;
;
        timeunit 1ns;
        timeprecision 1ps;

        localparam int DEPTH = 64;
        localparam int IDX_W = $clog2(DEPTH);
        // Reset, then tests 1 to 6 at 9, 49, 35, 45, 25 and 184 cycles, plus margin.
        localparam int MAX_CYCLES = 16 + 347 + 50;

        logic i_clk = 1'b0;
        logic i_reset = 1'b1;
        logic i_flush = 1'b0;
        logic i_stall = 1'b0;
        logic i_val = 1'b0;
        logic [31:0] i_inst = '0;
        logic [31:0] i_pc = '0;
        logic [3:0] i_flags = '0;
        logic o_pred_val, o_pred_taken, o_retire_val, o_mispredict, o_redirect;
        logic [31:0] o_pred_target, o_retire_pc, o_redirect_pc;

        int seed = 96;
        int errors = 0;
        int test_errors = 0;
        int tests = 0;
        int cycles = 0;

        // Reference pipeline state and counter table.
        ctr_t m_ctr [DEPTH];
        logic p_val = 0, d_val = 0, e_val = 0, r_val = 0, r_mis = 0, u_val = 0;
        logic p_taken, d_isbr, d_pred, e_isbr, e_pred, e_act, u_hit;
        logic [31:0] p_pc, p_inst, d_pc, d_inst, d_tgt, e_pc, e_tgt, r_pc, r_tgt;
        int u_idx;

        branch_unit_top #(.TABLE_DEPTH(DEPTH)) dut (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_flush       (i_flush),
                .i_stall       (i_stall),
                .i_val         (i_val),
                .i_inst        (i_inst),
                .i_pc          (i_pc),
                .i_flags       (i_flags),
                .o_pred_val    (o_pred_val),
                .o_pred_taken  (o_pred_taken),
                .o_pred_target (o_pred_target),
                .o_retire_val  (o_retire_val),
                .o_retire_pc   (o_retire_pc),
                .o_mispredict  (o_mispredict),
                .o_redirect    (o_redirect),
                .o_redirect_pc (o_redirect_pc)
        );

        always #20 i_clk = ~i_clk;

        always @(posedge i_clk)
        begin
                cycles++;
                if (cycles >= MAX_CYCLES)
                begin
                        $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
                        $display("Test failures found");
                        $finish;
                end
        end

        // ARM conditions come in pairs; odd codes invert the even one, NV never holds.
        function automatic logic cond_holds(logic [3:0] c, logic [3:0] f);
                logic r;
                case (c[3:1])
                3'd0: r = f[2];
                3'd1: r = f[1];
                3'd2: r = f[3];
                3'd3: r = f[0];
                3'd4: r = f[1] && !f[2];
                3'd5: r = (f[3] == f[0]);
                3'd6: r = !f[2] && (f[3] == f[0]);
                default: r = 1'b1;
                endcase
                if (c == 4'hF)
                        return 1'b0;
                return c[0] ? !r : r;
        endfunction

        function automatic logic [31:0] word_offset(logic [23:0] off);
                return {{6{off[23]}}, off, 2'b00};
        endfunction

        function automatic logic [31:0] branch_word(logic [3:0] cond, logic [23:0] off);
                return {cond, 3'b101, 1'b0, off};
        endfunction

        function automatic logic [31:0] other_word(logic [3:0] cond);
                return {cond, 3'b000, 25'h0};
        endfunction

        always @(posedge i_clk)
        begin
                logic rd;
                logic mis;
                rd = m_ctr[i_pc[IDX_W+1:2]][1];
                if (i_reset)
                begin
                        for (int i = 0; i < DEPTH; i++)
                                m_ctr[i] = SNT;
                        {p_val, d_val, e_val, r_val, r_mis, u_val} = '0;
                end
                else
                begin
                        if (u_val && !i_stall)
                                m_ctr[u_idx] = u_hit ? ctr_on_hit(m_ctr[u_idx]) :
                                                       ctr_on_miss(m_ctr[u_idx]);
                        // Flush wins over stall.
                        if (i_flush)
                        begin
                                {p_val, d_val, e_val, r_val, r_mis, u_val} = '0;
                        end
                        else if (!i_stall)
                        begin
                                mis = e_val && e_isbr && (e_pred != e_act);
                                r_val = e_val;
                                r_pc = e_pc;
                                r_mis = mis;
                                r_tgt = e_tgt;
                                u_val = e_val && e_isbr;
                                u_idx = e_pc[IDX_W+1:2];
                                u_hit = !mis;
                                if (mis)
                                begin
                                        {p_val, d_val, e_val} = '0;
                                end
                                else
                                begin
                                        e_val = d_val;
                                        e_pc = d_pc;
                                        e_isbr = d_isbr;
                                        e_pred = d_pred;
                                        e_act = d_isbr && cond_holds(d_inst[31:28], i_flags);
                                        e_tgt = e_act ? d_pc + 8 + word_offset(d_inst[23:0]) :
                                                        d_pc + 4;
                                        d_val = p_val;
                                        d_pc = p_pc;
                                        d_inst = p_inst;
                                        d_isbr = p_val && (p_inst[27:25] == 3'b101);
                                        d_pred = d_isbr && p_taken;
                                        d_tgt = p_pc + 8 + word_offset(p_inst[23:0]);
                                        p_val = i_val;
                                        p_pc = i_pc;
                                        p_inst = i_inst;
                                        p_taken = rd;
                                end
                        end
                end
        end

        task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
                errors++;
                test_errors++;
                $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        endtask

        a_pred_val: assert property (@(posedge i_clk) disable iff (i_reset)
                o_pred_val == (d_val && d_isbr))
                else mismatch("o_pred_val", $sampled(o_pred_val), $sampled(d_val && d_isbr));
        a_pred_taken: assert property (@(posedge i_clk) disable iff (i_reset)
                o_pred_taken == (d_val && d_pred))
                else mismatch("o_pred_taken", $sampled(o_pred_taken), $sampled(d_val && d_pred));
        a_pred_target: assert property (@(posedge i_clk) disable iff (i_reset)
                (d_val && d_isbr) |-> o_pred_target == d_tgt)
                else mismatch("o_pred_target", $sampled(o_pred_target), $sampled(d_tgt));
        a_retire_val: assert property (@(posedge i_clk) disable iff (i_reset)
                o_retire_val == r_val)
                else mismatch("o_retire_val", $sampled(o_retire_val), $sampled(r_val));
        a_retire_pc: assert property (@(posedge i_clk) disable iff (i_reset)
                r_val |-> o_retire_pc == r_pc)
                else mismatch("o_retire_pc", $sampled(o_retire_pc), $sampled(r_pc));
        a_mispredict: assert property (@(posedge i_clk) disable iff (i_reset)
                o_mispredict == r_mis)
                else mismatch("o_mispredict", $sampled(o_mispredict), $sampled(r_mis));
        a_redirect: assert property (@(posedge i_clk) disable iff (i_reset)
                o_redirect == r_mis)
                else mismatch("o_redirect", $sampled(o_redirect), $sampled(r_mis));
        a_redirect_pc: assert property (@(posedge i_clk) disable iff (i_reset)
                r_mis |-> o_redirect_pc == r_tgt)
                else mismatch("o_redirect_pc", $sampled(o_redirect_pc), $sampled(r_tgt));

        // Inputs change 2 ns after the edge.
        task automatic step(logic v, logic [31:0] inst, logic [31:0] pc, logic st, logic fl);
                @(posedge i_clk);
                #2;
                i_val = v;
                i_inst = inst;
                i_pc = pc;
                i_stall = st;
                i_flush = fl;
        endtask

        task automatic idle(int n);
                repeat (n) step(1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
        endtask

        task automatic single_pass(logic [31:0] inst, logic [31:0] pc);
                step(1'b1, inst, pc, 1'b0, 1'b0);
                idle(6);
        endtask

        task automatic end_test(string name);
                tests++;
                $display("test %s finished with %0d errors", name, test_errors);
                test_errors = 0;
        endtask

        initial
        begin
                logic [31:0] r;
                logic [31:0] inst;
                logic [31:0] pc;
                repeat (16) @(posedge i_clk);
                #2;
                i_reset = 1'b0;

                idle(2);
                single_pass(branch_word(4'hE, 24'h10), 32'h100);
                end_test("reset_state");

                repeat (4) single_pass(branch_word(4'hE, 24'h10), 32'h100);
                repeat (3) single_pass(branch_word(4'hF, 24'h10), 32'h100);
                end_test("counter_training");

                repeat (3) single_pass(branch_word(4'hE, 24'hFFFFF0), 32'h200);
                single_pass(other_word(4'hE), 32'h200 + DEPTH * 4);
                single_pass(other_word(4'hE), 32'h200);
                end_test("non_branch");

                // Untrained entry, so this taken branch mispredicts.
                step(1'b1, branch_word(4'hE, 24'h40), 32'h380, 1'b0, 1'b0);
                for (int k = 1; k <= 5; k++)
                        step(1'b1, other_word(4'hE), 32'h380 + 4 * k, 1'b0, 1'b0);
                idle(6);
                repeat (3) single_pass(branch_word(4'hE, 24'h8), 32'h400);
                i_flags = 4'b0000;
                step(1'b1, branch_word(4'h0, 24'h8), 32'h400, 1'b0, 1'b0);
                for (int k = 1; k <= 5; k++)
                        step(1'b1, other_word(4'hE), 32'h400 + 4 * k, 1'b0, 1'b0);
                idle(6);
                end_test("squash");

                for (int k = 0; k < 6; k++)
                begin
                        inst = (k % 2) ? other_word(4'hE) : branch_word(4'hE, 24'h10);
                        step(1'b1, inst, 32'h100 + 4 * k, 1'b0, 1'b0);
                        if (k == 3)
                                repeat (3) step(1'b1, inst, 32'h100 + 4 * k, 1'b1, 1'b0);
                end
                idle(6);
                for (int k = 0; k < 3; k++)
                        step(1'b1, other_word(4'hE), 32'h500 + 4 * k, 1'b0, 1'b0);
                step(1'b1, branch_word(4'hE, 24'h10), 32'h100, 1'b0, 1'b1);
                idle(6);
                end_test("stall_flush");

                for (int b = 0; b < 4; b++)
                begin
                        i_flags = $random(seed);
                        for (int k = 0; k < 20; k++)
                        begin
                                r = $random(seed);
                                pc = 32'h1000 + {r[3:0], 2'b00};
                                inst = r[4] ? branch_word(r[8:5], {{16{r[20]}}, r[20:13]}) :
                                              other_word(r[8:5]);
                                step(1'b1, inst, pc, 1'b0, 1'b0);
                                if (r[27:25] == 3'd0)
                                        step(1'b1, inst, pc, 1'b1, 1'b0);
                        end
                        idle(6);
                end
                end_test("random_mix");

                $display("%0d tests run, %0d errors", tests, errors);
                if (errors == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        end

endmodule

`default_nettype wire

// ==== files.f ====
source/isa_pkg.sv
source/predict_pkg.sv
source/branch_predict.sv
source/branch_decode.sv
source/branch_execute.sv
source/branch_result.sv
source/branch_unit_top.sv
verification/tb_branch_unit.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - source/isa_pkg.sv
  - source/predict_pkg.sv
  - source/branch_predict.sv
  - source/branch_decode.sv
  - source/branch_execute.sv
  - source/branch_result.sv
  - source/branch_unit_top.sv
  - target: simulation
    files:
      - verification/tb_branch_unit.sv
